// File: sub_bus_pkg.sv
//***********************************************************
// Sub-processor bus package
//   Address map regions and pages of the sub bus
//   Shared RAM and host window sizes
//   APB register offsets and the open-bus value
//   sub_addr_t, the sub address seen as ROM or as I/O
//***********************************************************
`default_nettype none

package sub_bus_pkg;

    localparam int RAM_AW      = 10;  // 1 KiB shared RAM
    localparam int HOST_RAM_AW = 9;   // Host sees the lower half
    localparam int APB_AW      = 10;

    localparam logic [1:0] REGION_IO    = 2'b11;  // 0xC000 and up
    localparam logic [1:0] PAGE_RAM     = 2'd0;   // 0xC000
    localparam logic [1:0] PAGE_NMI_ACK = 2'd1;   // 0xD000
    localparam logic [1:0] PAGE_IRQ     = 2'd2;   // 0xE000

    localparam logic [APB_AW-1:0] REG_CTRL   = 10'h200;
    localparam logic [APB_AW-1:0] REG_STATUS = 10'h204;

    localparam logic [7:0] OPEN_BUS = 8'hFF;

    // Same 16 bits, decoded as ROM space or as the I/O pages
    typedef union packed {
        logic [15:0] word;
        struct packed {
            logic [1:0]  region;
            logic [13:0] offset;
        } rom;
        struct packed {
            logic [1:0]        region;
            logic [1:0]        page;
            logic [1:0]        bank;
            logic [RAM_AW-1:0] offset;
        } io;
    } sub_addr_t;

endpackage

`default_nettype wire

// File: sub_isa_pkg.sv
//***********************************************************
// Sub-processor instruction set package
//   Opcode byte values of the accumulator machine
//   Instruction length in bytes
//***********************************************************
`default_nettype none

package sub_isa_pkg;

    // Every instruction is opcode, address low, address high.
    // Any other opcode byte runs as a no-op
    localparam int INSN_BYTES = 3;

    localparam logic [7:0] OP_LDA = 8'h01;  // acc = mem
    localparam logic [7:0] OP_ADD = 8'h02;  // acc += mem
    localparam logic [7:0] OP_XOR = 8'h03;  // acc ^= mem
    localparam logic [7:0] OP_STA = 8'h04;  // mem = acc
    localparam logic [7:0] OP_JMP = 8'h05;  // pc = address
    localparam logic [7:0] OP_WAI = 8'h06;  // Wait for NMI

endpackage

`default_nettype wire

// File: sub_addr_decode.sv
//***********************************************************
// Sub bus address decoder
//   ROM, shared RAM, NMI ack and main IRQ selects
//   Read data multiplexer with open-bus default
//***********************************************************
`timescale 1ns/100ps
`default_nettype none

module sub_addr_decode import sub_bus_pkg::*; (
    input  sub_addr_t  addr,
    input  logic       rd,
    input  logic       wr,
    input  logic [7:0] rom_data,
    input  logic [7:0] ram_q,
    output logic       rom_cs,
    output logic       ram_cs,
    output logic       nmi_ack,
    output logic       irq_main,
    output logic [7:0] rdata
);

    always_comb begin
        rom_cs   = 1'b0;
        ram_cs   = 1'b0;
        nmi_ack  = 1'b0;
        irq_main = 1'b0;
        if (rd || wr) begin
            if (addr.rom.region != REGION_IO) begin
                rom_cs = rd;  // Below 0xC000
            end else begin
                case (addr.io.page)
                    PAGE_RAM:     ram_cs   = addr.io.bank == 2'b00;
                    PAGE_NMI_ACK: nmi_ack  = wr;
                    PAGE_IRQ:     irq_main = wr;
                    default: ;
                endcase
            end
        end
        if (rom_cs)      rdata = rom_data;
        else if (ram_cs) rdata = ram_q;
        else             rdata = OPEN_BUS;
    end

endmodule

`default_nettype wire

// File: shared_ram.sv
//***********************************************************
// Shared RAM
//   True dual-port 1024x8, one port per side
//   Registered read data on both ports
//***********************************************************
`timescale 1ns/100ps
`default_nettype none

module shared_ram import sub_bus_pkg::*; (
    input  logic              clk,
    input  logic [RAM_AW-1:0] a_addr,
    input  logic [7:0]        a_wdata,
    input  logic              a_we,
    output logic [7:0]        a_q,
    input  logic [RAM_AW-1:0] b_addr,
    input  logic [7:0]        b_wdata,
    input  logic              b_we,
    output logic [7:0]        b_q
);

    logic [7:0] mem [2**RAM_AW];

    // Read before write on each port
    always_ff @(posedge clk) begin
        if (a_we) mem[a_addr] <= a_wdata;
        if (b_we) mem[b_addr] <= b_wdata;
        a_q <= mem[a_addr];
        b_q <= mem[b_addr];
    end

    // Sub and host must not collide on one byte
    a_no_write_clash: assert property (
        @(posedge clk) !(a_we && b_we && a_addr == b_addr)
    );

endmodule

`default_nettype wire

// File: sub_core.sv
//***********************************************************
// Sub-processor core
//   Three-byte fetch and execute sequencer
//   Accumulator, program counter and NMI latch
//   ROM wait handshake and one-cycle data wait
//   Bus grant by halting at instruction boundaries
//***********************************************************
`timescale 1ns/100ps
`default_nettype none

module sub_core import sub_bus_pkg::*, sub_isa_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       nmi_set,
    input  logic       nmi_ack,
    input  logic       halt_req,
    output logic       halted,
    output sub_addr_t  addr,
    output logic [7:0] wdata,
    output logic       rd,
    output logic       wr,
    input  logic [7:0] rdata,
    input  logic       rom_ok,
    input  logic       rom_cs
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_FETCH = 2'd1;
    localparam logic [1:0] S_EXEC  = 2'd2;
    localparam logic [1:0] S_HALT  = 2'd3;

    logic [1:0]  state;
    logic [1:0]  idx;          // Byte of the instruction being fetched
    logic [15:0] pc;           // Start of the current instruction
    logic [7:0]  acc;
    logic [7:0]  opcode;
    logic [7:0]  op_lo;
    logic [7:0]  op_hi;
    logic        nmi_latch;
    logic        nmi_set_q;
    logic        wait_q;       // Second cycle of a RAM or open-bus read
    logic        data_ok;
    logic        is_read;
    logic [15:0] operand;
    logic [15:0] pc_next;
    logic [1:0]  boundary_next;

    assign operand       = {op_hi, op_lo};
    assign pc_next       = pc + 16'(INSN_BYTES);
    assign is_read       = opcode == OP_LDA || opcode == OP_ADD || opcode == OP_XOR;
    assign data_ok       = rom_cs ? rom_ok : wait_q;
    assign boundary_next = halt_req ? S_HALT : S_FETCH;  // Grant only here

    assign halted    = state == S_HALT;
    assign rd        = state == S_FETCH || (state == S_EXEC && is_read);
    assign wr        = state == S_EXEC && opcode == OP_STA;  // One cycle, EXEC leaves
    assign wdata     = acc;
    assign addr.word = (state == S_EXEC) ? operand : pc + 16'(idx);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_IDLE;
            idx       <= 2'd0;
            pc        <= 16'h0000;
            acc       <= 8'h00;
            nmi_latch <= 1'b0;
            nmi_set_q <= 1'b0;
            wait_q    <= 1'b0;
        end else begin
            nmi_set_q <= nmi_set;
            wait_q    <= rd && !rom_cs && !wait_q;
            if (nmi_set && !nmi_set_q) nmi_latch <= 1'b1;  // Rising edge wins
            else if (nmi_ack)          nmi_latch <= 1'b0;
            case (state)
                S_IDLE: state <= boundary_next;
                S_FETCH: begin
                    if (data_ok) begin
                        if (idx == 2'(INSN_BYTES - 1)) begin
                            idx   <= 2'd0;
                            state <= S_EXEC;
                        end else begin
                            idx <= idx + 2'd1;
                        end
                    end
                end
                S_EXEC: begin
                    case (opcode)
                        OP_LDA, OP_ADD, OP_XOR: begin
                            if (data_ok) begin
                                if (opcode == OP_LDA)      acc <= rdata;
                                else if (opcode == OP_ADD) acc <= acc + rdata;
                                else                       acc <= acc ^ rdata;
                                pc    <= pc_next;
                                state <= boundary_next;
                            end
                        end
                        OP_JMP: begin
                            pc    <= operand;
                            state <= boundary_next;
                        end
                        OP_WAI: begin
                            // pc stays on WAI so a halted wait resumes waiting
                            if (nmi_latch) begin
                                pc    <= pc_next;
                                state <= boundary_next;
                            end else if (halt_req) begin
                                state <= S_HALT;
                            end
                        end
                        default: begin  // STA and unknown opcodes
                            pc    <= pc_next;
                            state <= boundary_next;
                        end
                    endcase
                end
                default: if (!halt_req) state <= S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH && data_ok) begin
            case (idx)
                2'd0:    opcode <= rdata;
                2'd1:    op_lo  <= rdata;
                default: op_hi  <= rdata;
            endcase
        end
    end

    // Sub write strobe lasts a single cycle
    a_wr_pulse: assert property (
        @(posedge clk) disable iff (reset) wr |=> !wr
    );

    // ROM request held with the same address until taken
    a_rom_hold: assert property (
        @(posedge clk) disable iff (reset) rom_cs && !rom_ok |=> rom_cs && $stable(addr)
    );

endmodule

`default_nettype wire

// File: sub_cpu_sys.sv
//***********************************************************
// Sub-processor subsystem
//   Core, address decoder and shared RAM
//   Sub write strobe gated by the RAM select
//   Host RAM port mapped onto the lower RAM half
//***********************************************************
`timescale 1ns/100ps
`default_nettype none

module sub_cpu_sys import sub_bus_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   halt_req,
    output logic                   halted,
    input  logic                   nmi_set,
    output logic                   irq_main,
    input  logic [HOST_RAM_AW-1:0] host_addr,
    input  logic [7:0]             host_wdata,
    input  logic                   host_we,
    output logic [7:0]             host_rdata,
    output logic [15:0]            rom_addr,
    output logic                   rom_cs,
    input  logic [7:0]             rom_data,
    input  logic                   rom_ok
);

    sub_addr_t         core_addr;
    logic [7:0]        core_wdata;
    logic [7:0]        core_rdata;
    logic              core_rd;
    logic              core_wr;
    logic              ram_cs;
    logic              ram_we;
    logic              nmi_ack;
    logic [7:0]        ram_q;
    logic [RAM_AW-1:0] host_ram_addr;

    assign rom_addr      = core_addr.word;
    assign ram_we        = core_wr && ram_cs;
    assign host_ram_addr = {1'b0, host_addr};  // Lower 512 bytes only

    sub_core u_core (
        .clk      (clk),
        .reset    (reset),
        .nmi_set  (nmi_set),
        .nmi_ack  (nmi_ack),
        .halt_req (halt_req),
        .halted   (halted),
        .addr     (core_addr),
        .wdata    (core_wdata),
        .rd       (core_rd),
        .wr       (core_wr),
        .rdata    (core_rdata),
        .rom_ok   (rom_ok),
        .rom_cs   (rom_cs)
    );

    sub_addr_decode u_decode (
        .addr     (core_addr),
        .rd       (core_rd),
        .wr       (core_wr),
        .rom_data (rom_data),
        .ram_q    (ram_q),
        .rom_cs   (rom_cs),
        .ram_cs   (ram_cs),
        .nmi_ack  (nmi_ack),
        .irq_main (irq_main),
        .rdata    (core_rdata)
    );

    shared_ram u_ram (
        .clk     (clk),
        .a_addr  (core_addr.io.offset),
        .a_wdata (core_wdata),
        .a_we    (ram_we),
        .a_q     (ram_q),
        .b_addr  (host_ram_addr),
        .b_wdata (host_wdata),
        .b_we    (host_we),
        .b_q     (host_rdata)
    );

endmodule

`default_nettype wire

// File: host_apb_bridge.sv
//***********************************************************
// Host APB bridge
//   APB3 slave for the main host
//   Shared RAM window, writes allowed only while halted
//   Control register with halt request and NMI pulse
//   Status register with halted and IRQ pending
//***********************************************************
`timescale 1ns/100ps
`default_nettype none

module host_apb_bridge import sub_bus_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [APB_AW-1:0]      paddr,
    input  logic [7:0]             pwdata,
    output logic [7:0]             prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   halt_req,
    output logic                   nmi_set,
    input  logic                   halted,
    input  logic                   irq_main,
    output logic [HOST_RAM_AW-1:0] host_addr,
    output logic [7:0]             host_wdata,
    output logic                   host_we,
    input  logic [7:0]             host_rdata
);

    logic       access;
    logic       ram_sel;
    logic       rd_wait;      // RAM read data lands one cycle late
    logic       irq_pending;
    logic       ctrl_wr;
    logic       status_rd;
    logic [7:0] reg_rdata;

    assign access    = psel && penable;
    assign ram_sel   = paddr[APB_AW-1:HOST_RAM_AW] == '0;
    assign pready    = access && (!ram_sel || pwrite || rd_wait);
    assign pslverr   = access && ram_sel && pwrite && !halted;
    assign host_we   = access && ram_sel && pwrite && halted;
    assign ctrl_wr   = access && pwrite && paddr == REG_CTRL;
    assign status_rd = access && !pwrite && paddr == REG_STATUS;

    assign host_addr  = paddr[HOST_RAM_AW-1:0];
    assign host_wdata = pwdata;

    always_comb begin
        case (paddr)
            REG_CTRL:   reg_rdata = {7'b0, halt_req};
            REG_STATUS: reg_rdata = {6'b0, irq_pending, halted};
            default:    reg_rdata = 8'h00;
        endcase
    end

    assign prdata = ram_sel ? host_rdata : reg_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_wait     <= 1'b0;
            halt_req    <= 1'b0;
            nmi_set     <= 1'b0;
            irq_pending <= 1'b0;
        end else begin
            rd_wait <= access && ram_sel && !pwrite && !rd_wait;
            nmi_set <= ctrl_wr && pwdata[1];   // Self-clearing pulse
            if (ctrl_wr) halt_req <= pwdata[0];
            if (irq_main)       irq_pending <= 1'b1;
            else if (status_rd) irq_pending <= 1'b0;  // Clear on read
        end
    end

    // Completion only in an access phase that followed a setup
    a_pready_access: assert property (
        @(posedge clk) disable iff (reset) pready |-> penable && $past(psel)
    );

endmodule

`default_nettype wire

// File: sub_top.sv
//***********************************************************
// Sub-processor board block, top level
//   Host APB bridge beside the sub-processor subsystem
//***********************************************************
`timescale 1ns/100ps
`default_nettype none

module sub_top import sub_bus_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [7:0]        pwdata,
    output logic [7:0]        prdata,
    output logic              pready,
    output logic              pslverr,
    output logic [15:0]       rom_addr,
    output logic              rom_cs,
    input  logic [7:0]        rom_data,
    input  logic              rom_ok
);

    logic                   halt_req;
    logic                   nmi_set;
    logic                   halted;
    logic                   irq_main;
    logic [HOST_RAM_AW-1:0] host_addr;
    logic [7:0]             host_wdata;
    logic                   host_we;
    logic [7:0]             host_rdata;

    host_apb_bridge u_bridge (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .halt_req   (halt_req),
        .nmi_set    (nmi_set),
        .halted     (halted),
        .irq_main   (irq_main),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_we    (host_we),
        .host_rdata (host_rdata)
    );

    sub_cpu_sys u_sub (
        .clk        (clk),
        .reset      (reset),
        .halt_req   (halt_req),
        .halted     (halted),
        .nmi_set    (nmi_set),
        .irq_main   (irq_main),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_we    (host_we),
        .host_rdata (host_rdata),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok)
    );

endmodule

`default_nettype wire

// File: tb_rom_model.sv
//***********************************************************
// ROM model for the sub-processor testbench
//   Test program image, no-op bytes elsewhere
//   rom_ok after a random wait of 0 to 3 cycles
//***********************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_rom_model import sub_isa_pkg::*; #(
    parameter int unsigned SEED = 32'h1
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] rom_addr,
    input  logic        rom_cs,
    output logic [7:0]  rom_data,
    output logic        rom_ok
);

    // Opcode, address low, address high
    localparam logic [7:0] IMAGE [24] = '{
        OP_WAI, 8'h00, 8'h00,
        OP_STA, 8'h00, 8'hD0,  // Ack the NMI
        OP_LDA, 8'h00, 8'hC0,
        OP_ADD, 8'h01, 8'hC0,
        OP_XOR, 8'h00, 8'hF0,  // Open bus, reads 0xFF
        OP_STA, 8'h02, 8'hC0,
        OP_STA, 8'h00, 8'hE0,  // Interrupt to the host
        OP_JMP, 8'h00, 8'h00
    };

    initial begin
        int unsigned delay;
        logic        busy;
        void'($urandom(SEED));
        delay    = 0;
        busy     = 1'b0;
        rom_ok   = 1'b0;
        rom_data = 8'h00;
        forever begin
            @(posedge clk);
            #1;
            if (reset || !rom_cs) begin
                busy   = 1'b0;
                rom_ok = 1'b0;
            end else begin
                if (rom_ok) busy = 1'b0;  // Byte taken on this edge
                rom_ok = 1'b0;
                if (!busy) begin
                    busy  = 1'b1;
                    delay = $urandom % 4;
                end
                if (delay == 0) begin
                    rom_ok   = 1'b1;
                    rom_data = (rom_addr < 16'd24) ? IMAGE[rom_addr[4:0]] : 8'h00;
                end else begin
                    delay--;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_sub_top.sv
//***********************************************************
// Testbench for the sub-processor board block
//   Clock, reset and APB host tasks
//   ROM model with random fetch waits
//   Add-and-invert commands run by the sub-processor
//   Assertions, error count and watchdog
//***********************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_sub_top import sub_bus_pkg::*; ();

    localparam int NUM_CMDS    = 20;
    localparam int WATCHDOG_NS = 40000 * (NUM_CMDS + 1);  // Extra slot for the first checks

    localparam logic [APB_AW-1:0] ADDR_X     = 10'h000;  // Sub sees 0xC000
    localparam logic [APB_AW-1:0] ADDR_Y     = 10'h001;
    localparam logic [APB_AW-1:0] ADDR_RES   = 10'h002;
    localparam logic [APB_AW-1:0] ADDR_SPARE = 10'h010;

    logic              clk;
    logic              reset;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [7:0]        pwdata;
    logic [7:0]        prdata;
    logic              pready;
    logic              pslverr;
    logic [15:0]       rom_addr;
    logic              rom_cs;
    logic [7:0]        rom_data;
    logic              rom_ok;
    int                errors;
    int                checks;

    sub_top DUT (
        .clk      (clk),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok)
    );

    tb_rom_model #(.SEED(32'hb22f)) u_rom (
        .clk      (clk),
        .reset    (reset),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok)
    );

    always #50 clk = ~clk;

    // Slave error only ends a write
    a_err_on_write: assert property (
        @(posedge clk) disable iff (reset) pslverr |-> pready && pwrite
    ) else begin
        errors++;
        $display("pslverr was raised outside a completing write");
    end

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        checks++;
        a_value: assert (got === exp) else begin
            errors++;
            $display("Error %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // One APB transfer, setup then access until pready
    task automatic apb_access(input logic wr, input logic [APB_AW-1:0] a,
                              input logic [7:0] d, output logic [7:0] q,
                              output logic err);
        int waits;
        int exp_waits;
        exp_waits = (!wr && a < 10'h200) ? 1 : 0;  // RAM reads only
        waits     = 0;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = d;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        q   = prdata;
        err = pslverr;
        check_value("pready wait cycles", 8'(waits), 8'(exp_waits));
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_byte(input logic [APB_AW-1:0] a, input logic [7:0] d,
                              input logic exp_err);
        logic [7:0] q;
        logic       err;
        apb_access(1'b1, a, d, q, err);
        check_value("pslverr", 8'(err), 8'(exp_err));
    endtask

    task automatic read_byte(input logic [APB_AW-1:0] a, output logic [7:0] q);
        logic err;
        apb_access(1'b0, a, 8'h00, q, err);
        check_value("pslverr", 8'(err), 8'h00);
    endtask

    task automatic halt_sub();
        logic [7:0] status;
        write_byte(REG_CTRL, 8'h01, 1'b0);
        do begin
            read_byte(REG_STATUS, status);
            check_value("status irq while halting", 8'(status[1]), 8'h00);
        end while (!status[0]);
    endtask

    // Pending bit seen once, then cleared by that read
    task automatic wait_irq();
        logic [7:0] status;
        do read_byte(REG_STATUS, status); while (!status[1]);
        read_byte(REG_STATUS, status);
        check_value("status irq after read", 8'(status[1]), 8'h00);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout, the run did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [7:0] q;
        logic [7:0] x;
        logic [7:0] y;
        errors  = 0;
        checks  = 0;
        clk     = 1'b0;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = 8'h00;

        repeat (15) @(posedge clk);
        @(negedge clk);
        check_value("pready", 8'(pready), 8'h00);
        check_value("pslverr", 8'(pslverr), 8'h00);
        check_value("rom_cs", 8'(rom_cs), 8'h00);
        @(posedge clk);
        #1;
        reset = 1'b0;
        read_byte(REG_STATUS, q);
        check_value("status", q, 8'h00);  // Not halted, nothing pending

        // Blocked write while the sub runs
        halt_sub();
        write_byte(ADDR_SPARE, 8'h3C, 1'b0);
        write_byte(REG_CTRL, 8'h00, 1'b0);
        do read_byte(REG_STATUS, q); while (q[0]);
        write_byte(ADDR_SPARE, 8'hC3, 1'b1);
        read_byte(ADDR_SPARE, q);
        check_value("ram spare", q, 8'h3C);

        for (int i = 0; i < NUM_CMDS; i++) begin
            x = 8'(i * 53 + 17);
            y = 8'(i * 29 + 200);
            halt_sub();
            write_byte(ADDR_X, x, 1'b0);
            write_byte(ADDR_Y, y, 1'b0);
            read_byte(ADDR_X, q);
            check_value("ram x", q, x);
            read_byte(ADDR_Y, q);
            check_value("ram y", q, y);
            write_byte(REG_CTRL, 8'h02, 1'b0);  // Release plus NMI
            wait_irq();
            halt_sub();
            read_byte(ADDR_RES, q);
            check_value("result", q, 8'(x + y) ^ 8'hFF);
        end

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
sub_bus_pkg.sv
sub_isa_pkg.sv
sub_addr_decode.sv
shared_ram.sv
sub_core.sv
sub_cpu_sys.sv
host_apb_bridge.sv
sub_top.sv
tb_rom_model.sv
tb_sub_top.sv

// File: run.sh
#!/bin/sh
# Build the sub-processor testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_sub_top -f sources.f

out=$(./obj_dir/Vtb_sub_top)
echo "$out"

if echo "$out" | grep -Fqx -e '>>> PASS'; then
    exit 0
fi
exit 1
